// File: verilog/sgmii_apb_pkg.sv
package sgmii_apb_pkg;

  // --------------------
  // Field widths
  // --------------------
  localparam int paddr_w     = 19;
  localparam int pdata_w     = 32;
  localparam int core_idx_w  = 5;
  localparam int core_data_w = 16;
  localparam int hsst_addr_w = 16;
  localparam int hsst_data_w = 8;

  // Address bit that steers an access to the SGMII core
  localparam int core_sel_bit = 18;

  // Access direction, taken straight from pwrite
  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } apb_op_e;

  // --------------------
  // Request structs
  // --------------------
  typedef struct packed
  {
    logic [paddr_w-1:0] paddr;
    logic               pwrite;
    logic               psel;
    logic               penable;
    logic [pdata_w-1:0] pwdata;
  } apb_req_t;

  typedef struct packed
  {
    logic [core_idx_w-1:0]  index;
    logic                   write;
    logic                   sel;
    logic                   enable;
    logic [core_data_w-1:0] wdata;
  } core_req_t;

  // Serdes side uses the full byte index, the bank folds it down
  typedef struct packed
  {
    logic [hsst_addr_w-1:0] addr;
    logic                   write;
    logic                   sel;
    logic                   enable;
    logic [hsst_data_w-1:0] wdata;
  } hsst_req_t;

endpackage

// File: verilog/sgmii_reg_pkg.sv
package sgmii_reg_pkg;

  // --------------------
  // Core register map
  // --------------------
  typedef enum logic [4:0]
  {
    reg_control       = 5'd0,
    reg_status        = 5'd1,
    reg_id_hi         = 5'd2,
    reg_id_lo         = 5'd3,
    reg_advert        = 5'd4,
    reg_scratch_first = 5'd5,
    reg_scratch_last  = 5'd15
  } core_reg_e;

  localparam int scratch_words = int'(reg_scratch_last) - int'(reg_scratch_first) + 1;

  // Identifier words, read only
  localparam logic [15:0] core_id_hi = 16'h5347;
  localparam logic [15:0] core_id_lo = 16'h0110;

  // Bit positions inside control and status
  localparam int control_soft_rst_bit = 15;
  localparam int status_link_bit      = 2;
  localparam int status_an_bit        = 5;

  // --------------------
  // Serdes register bank
  // --------------------
  // Only 64 bytes are modelled, higher indexes alias
  localparam int hsst_bank_bytes = 64;
  localparam int hsst_idx_w      = 6;

  typedef enum logic [1:0]
  {
    st_idle = 2'd0,
    st_wait = 2'd1,
    st_done = 2'd2
  } hsst_state_e;

endpackage

// File: verilog/sgmii_apb_union.sv
`timescale 1ns/1ps

module sgmii_apb_union #(
  parameter bit management_interface = 1'b0
)(
  input  logic                                  pclk,
  input  logic                                  rst_n,
  input  sgmii_apb_pkg::apb_req_t               apb_req,
  output logic [sgmii_apb_pkg::pdata_w-1:0]     prdata,
  output logic                                  pready,
  output sgmii_apb_pkg::core_req_t              core_req,
  input  logic [sgmii_apb_pkg::core_data_w-1:0] core_prdata,
  output sgmii_apb_pkg::hsst_req_t              hsst_req,
  input  logic [sgmii_apb_pkg::hsst_data_w-1:0] hsst_rdata,
  input  logic                                  hsst_ready
);

  logic                   core_sel;
  logic                   core_access;
  logic                   core_ready;
  logic [2:0]             enable_cnt;
  sgmii_apb_pkg::apb_op_e op;

  // Core path is absent when it is managed over MDIO
  assign core_sel    = !management_interface && apb_req.paddr[sgmii_apb_pkg::core_sel_bit];
  assign core_access = core_sel && apb_req.psel && apb_req.penable;
  assign op          = sgmii_apb_pkg::apb_op_e'(apb_req.pwrite);

  // --------------------
  // Request steering
  // --------------------
  always_comb
  begin
    core_req = '0;
    hsst_req = '0;
    if (core_sel)
    begin
      // Word index in paddr[6:2]
      core_req.index  = apb_req.paddr[6:2];
      core_req.write  = apb_req.pwrite;
      core_req.sel    = apb_req.psel;
      core_req.enable = apb_req.penable;
      core_req.wdata  = apb_req.pwdata[sgmii_apb_pkg::core_data_w-1:0];
    end
    else
    begin
      // Byte index in paddr[17:2]
      hsst_req.addr   = apb_req.paddr[17:2];
      hsst_req.write  = apb_req.pwrite;
      hsst_req.sel    = apb_req.psel;
      hsst_req.enable = apb_req.penable;
      hsst_req.wdata  = apb_req.pwdata[sgmii_apb_pkg::hsst_data_w-1:0];
    end
  end

  // --------------------
  // Core ready
  // --------------------
  // Counts cycles with penable high on a core access, saturating
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
      enable_cnt <= '0;
    else if (!core_access)
      enable_cnt <= '0;
    else if (enable_cnt != 3'd7)
      enable_cnt <= enable_cnt + 3'd1;
  end

  // Writes complete at once, reads wait for the count to reach 2
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
      core_ready <= 1'b0;
    else if (core_ready)
      core_ready <= 1'b0;
    else if (core_access)
      core_ready <= (op == sgmii_apb_pkg::op_write) || (enable_cnt == 3'd2);
    else
      core_ready <= 1'b0;
  end

  // --------------------
  // Result merge
  // --------------------
  assign prdata = core_sel ? {16'b0, core_prdata} : {24'b0, hsst_rdata};
  assign pready = core_sel ? core_ready : hsst_ready;

endmodule

// File: verilog/sgmii_core_regs.sv
`timescale 1ns/1ps

module sgmii_core_regs #(
  parameter bit management_interface = 1'b0
)(
  input  logic                                  pclk,
  input  logic                                  rst_n,
  input  sgmii_apb_pkg::core_req_t              core_req,
  input  logic                                  link_up,
  input  logic                                  an_complete,
  output logic [sgmii_apb_pkg::core_data_w-1:0] core_prdata
);

  sgmii_reg_pkg::core_reg_e reg_sel;
  logic [15:0]              control_q;
  logic [15:0]              advert_q;
  logic [15:0]              scratch_q [sgmii_reg_pkg::scratch_words];
  logic [15:0]              status;
  logic                     wr_en;
  logic                     soft_rst;
  logic                     in_scratch;
  logic [3:0]               scratch_idx;

  assign reg_sel = sgmii_reg_pkg::core_reg_e'(core_req.index);

  // Contents are frozen when the core is managed elsewhere
  assign wr_en = !management_interface && core_req.sel && core_req.enable && core_req.write;

  assign soft_rst = wr_en && (reg_sel == sgmii_reg_pkg::reg_control) &&
                    core_req.wdata[sgmii_reg_pkg::control_soft_rst_bit];

  assign in_scratch  = (core_req.index >= sgmii_reg_pkg::reg_scratch_first) &&
                       (core_req.index <= sgmii_reg_pkg::reg_scratch_last);
  assign scratch_idx = 4'(core_req.index - sgmii_reg_pkg::reg_scratch_first);

  // --------------------
  // Writable registers
  // --------------------
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      control_q <= '0;
      advert_q  <= '0;
      for (int i = 0; i < sgmii_reg_pkg::scratch_words; i++)
        scratch_q[i] <= '0;
    end
    else if (soft_rst)
    begin
      // Soft reset wins over the write itself, so bit 15 reads back 0
      control_q <= '0;
      advert_q  <= '0;
      for (int i = 0; i < sgmii_reg_pkg::scratch_words; i++)
        scratch_q[i] <= '0;
    end
    else if (wr_en)
    begin
      if (reg_sel == sgmii_reg_pkg::reg_control)
        control_q <= core_req.wdata;
      else if (reg_sel == sgmii_reg_pkg::reg_advert)
        advert_q <= core_req.wdata;
      else if (in_scratch)
        scratch_q[scratch_idx] <= core_req.wdata;
    end
  end

  // Status shows the link levels directly
  always_comb
  begin
    status = '0;
    status[sgmii_reg_pkg::status_link_bit] = link_up;
    status[sgmii_reg_pkg::status_an_bit]   = an_complete;
  end

  // --------------------
  // Read mux
  // --------------------
  always_comb
  begin
    core_prdata = '0;
    if (in_scratch)
      core_prdata = scratch_q[scratch_idx];
    else
    begin
      case (reg_sel)
        sgmii_reg_pkg::reg_control: core_prdata = control_q;
        sgmii_reg_pkg::reg_status:  core_prdata = status;
        sgmii_reg_pkg::reg_id_hi:   core_prdata = sgmii_reg_pkg::core_id_hi;
        sgmii_reg_pkg::reg_id_lo:   core_prdata = sgmii_reg_pkg::core_id_lo;
        sgmii_reg_pkg::reg_advert:  core_prdata = advert_q;
        // Indexes 16 to 31 are unmapped
        default:                    core_prdata = '0;
      endcase
    end
  end

endmodule

// File: verilog/hsst_apb_bank.sv
`timescale 1ns/1ps

module hsst_apb_bank #(
  parameter int hsst_wait_cycles = 2
)(
  input  logic                                  pclk,
  input  logic                                  rst_n,
  input  sgmii_apb_pkg::hsst_req_t              hsst_req,
  output logic [sgmii_apb_pkg::hsst_data_w-1:0] hsst_rdata,
  output logic                                  hsst_ready
);

  // Last count value spent in st_wait
  localparam logic [2:0] wait_last = 3'(hsst_wait_cycles - 1);

  sgmii_reg_pkg::hsst_state_e             state;
  logic [2:0]                             wait_cnt;
  logic [sgmii_apb_pkg::hsst_data_w-1:0]  mem [sgmii_reg_pkg::hsst_bank_bytes];
  logic [sgmii_reg_pkg::hsst_idx_w-1:0]   byte_idx;
  logic                                   access;

  // Upper index bits are ignored, so the bank repeats every 64 bytes
  assign byte_idx = hsst_req.addr[sgmii_reg_pkg::hsst_idx_w-1:0];
  assign access   = hsst_req.sel && hsst_req.enable;

  // --------------------
  // Wait state FSM
  // --------------------
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= sgmii_reg_pkg::st_idle;
      wait_cnt   <= '0;
      hsst_ready <= 1'b0;
    end
    else
    begin
      hsst_ready <= 1'b0;
      case (state)
        sgmii_reg_pkg::st_idle:
        begin
          wait_cnt <= '0;
          if (access)
          begin
            if (hsst_wait_cycles == 0)
            begin
              state      <= sgmii_reg_pkg::st_done;
              hsst_ready <= 1'b1;
            end
            else
              state <= sgmii_reg_pkg::st_wait;
          end
        end
        sgmii_reg_pkg::st_wait:
        begin
          if (wait_cnt == wait_last)
          begin
            state      <= sgmii_reg_pkg::st_done;
            hsst_ready <= 1'b1;
          end
          else
            wait_cnt <= wait_cnt + 3'd1;
        end
        // Ready is high for this one cycle only
        sgmii_reg_pkg::st_done: state <= sgmii_reg_pkg::st_idle;
        default:                state <= sgmii_reg_pkg::st_idle;
      endcase
    end
  end

  // --------------------
  // Byte array
  // --------------------
  // Write commits at the edge that ends st_done
  always_ff @(posedge pclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < sgmii_reg_pkg::hsst_bank_bytes; i++)
        mem[i] <= '0;
    end
    else if (state == sgmii_reg_pkg::st_done && hsst_req.sel && hsst_req.write)
      mem[byte_idx] <= hsst_req.wdata;
  end

  assign hsst_rdata = mem[byte_idx];

endmodule

// File: verilog/sgmii_mgmt_top.sv
`timescale 1ns/1ps

module sgmii_mgmt_top #(
  parameter bit management_interface = 1'b0,
  parameter int hsst_wait_cycles     = 2
)(
  input  logic                              pclk,
  input  logic                              rst_n,
  input  sgmii_apb_pkg::apb_req_t           apb_req,
  output logic [sgmii_apb_pkg::pdata_w-1:0] prdata,
  output logic                              pready,
  input  logic                              link_up,
  input  logic                              an_complete
);

  sgmii_apb_pkg::core_req_t              core_req;
  logic [sgmii_apb_pkg::core_data_w-1:0] core_prdata;
  sgmii_apb_pkg::hsst_req_t              hsst_req;
  logic [sgmii_apb_pkg::hsst_data_w-1:0] hsst_rdata;
  logic                                  hsst_ready;

  // Decode and result merge
  sgmii_apb_union #(
    .management_interface (management_interface)
  ) i_union (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .prdata      (prdata),
    .pready      (pready),
    .core_req    (core_req),
    .core_prdata (core_prdata),
    .hsst_req    (hsst_req),
    .hsst_rdata  (hsst_rdata),
    .hsst_ready  (hsst_ready)
  );

  sgmii_core_regs #(
    .management_interface (management_interface)
  ) i_core_regs (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .core_req    (core_req),
    .link_up     (link_up),
    .an_complete (an_complete),
    .core_prdata (core_prdata)
  );

  hsst_apb_bank #(
    .hsst_wait_cycles (hsst_wait_cycles)
  ) i_hsst_bank (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .hsst_req   (hsst_req),
    .hsst_rdata (hsst_rdata),
    .hsst_ready (hsst_ready)
  );

endmodule

// File: sim/tb_sgmii_mgmt.sv
`timescale 1ns/1ps

module tb_sgmii_mgmt;

  localparam int hsst_wait    = 2;
  localparam int pready_limit = 16;

  // Access cycles per test with 2 for a core write and 4 for a core read or serdes access
  localparam int t1_cycles   = 12 * 2 + 12 * 4;
  localparam int t2_cycles   = 2 + 4 + 4 + 4;
  localparam int t3_cycles   = 48 * 4;
  localparam int t4_cycles   = 4 * 4 + 3 * 2 + 3 * 4 + 16 * 4;
  localparam int t5_cycles   = 2 + 4 + 4 + 2 + 4 + 4;
  localparam int t6_cycles   = 2 + 4 + 2 + 13 * 4 + 4 * 4;
  localparam int cycle_limit =
    (t1_cycles + t2_cycles + t3_cycles + t4_cycles + t5_cycles + t6_cycles) * 2 + 100;

  logic                    pclk;
  logic                    rst_n;
  sgmii_apb_pkg::apb_req_t apb_req;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    link_up;
  logic                    an_complete;

  logic [19:0] lfsr_state;
  logic [15:0] ref_core [16];
  logic [7:0]  ref_hsst [64];
  int          errors;
  int          checks;
  int          test_errors_base;
  int          cycle_count;

  logic [18:0] cmp_addr;
  logic [31:0] cmp_got;
  logic [31:0] cmp_exp;
  event        read_done;

  sgmii_mgmt_top i_dut (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .prdata      (prdata),
    .pready      (pready),
    .link_up     (link_up),
    .an_complete (an_complete)
  );

  always #10 pclk = ~pclk;

  // Run limit
  initial
  begin
    cycle_count = 0;
    while (cycle_count < cycle_limit)
    begin
      @(posedge pclk);
      cycle_count++;
    end
    $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  // 20-bit Fibonacci LFSR with taps 20 and 17 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      fb         = lfsr_state[19] ^ lfsr_state[16];
      lfsr_state = {lfsr_state[18:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic logic [18:0] core_addr(input logic [4:0] index);
    return {1'b1, 11'b0, index, 2'b00};
  endfunction

  function automatic logic [18:0] hsst_addr(input logic [15:0] byte_index);
    return {1'b0, byte_index, 2'b00};
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] ref_read(input logic [18:0] addr);
    logic [4:0]  index;
    logic [15:0] word;
    index = addr[6:2];
    word  = '0;
    if (!addr[18])
      word = {8'b0, ref_hsst[addr[7:2]]};
    else if (index == 5'd1)
    begin
      word[2] = link_up;
      word[5] = an_complete;
    end
    else if (index == 5'd2)
      word = sgmii_reg_pkg::core_id_hi;
    else if (index == 5'd3)
      word = sgmii_reg_pkg::core_id_lo;
    else if (index < 5'd16)
      word = ref_core[index[3:0]];
    return {16'b0, word};
  endfunction

  function automatic void ref_write(input logic [18:0] addr, input logic [31:0] data);
    logic [4:0] index;
    index = addr[6:2];
    if (!addr[18])
      ref_hsst[addr[7:2]] = data[7:0];
    else if (index == 5'd0 && data[15])
    begin
      // Soft reset clears every writable word
      for (int i = 0; i < 16; i++)
        ref_core[i] = '0;
    end
    else if (index == 5'd0 || (index >= 5'd4 && index <= 5'd15))
      ref_core[index[3:0]] = data[15:0];
  endfunction

  function automatic int exp_cycles(input sgmii_apb_pkg::apb_op_e op, input logic [18:0] addr);
    if (!addr[18])
      return hsst_wait + 2;
    return (op == sgmii_apb_pkg::op_write) ? 2 : 4;
  endfunction

  // --------------------
  // APB master
  // --------------------
  task automatic apb_access(input sgmii_apb_pkg::apb_op_e op, input logic [18:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    @(posedge pclk);
    apb_req.paddr   <= addr;
    apb_req.pwrite  <= (op == sgmii_apb_pkg::op_write);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwdata  <= wdata;
    @(posedge pclk);
    apb_req.penable <= 1'b1;
    // Cycle 1 is the first edge that sees penable high
    while (!done && cycles < pready_limit)
    begin
      @(posedge pclk);
      cycles++;
      done = pready;
    end
    rdata = prdata;
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    checks++;
    assert (done)
    else
    begin
      $display("Error at %0t ns: pready did not rise within %0d cycles for address %h",
               $time, pready_limit, addr);
      errors++;
    end
    if (done)
    begin
      assert (cycles == exp_cycles(op, addr))
      else
      begin
        $display("Mismatch at %0t ns: pready cycle for address %h, expected %0d, got %0d",
                 $time, addr, exp_cycles(op, addr), cycles);
        errors++;
      end
    end
  endtask

  task automatic write_word(input logic [18:0] addr, input logic [31:0] data);
    logic [31:0] discard;
    apb_access(sgmii_apb_pkg::op_write, addr, data, discard);
    ref_write(addr, data);
  endtask

  task automatic read_check(input logic [18:0] addr);
    logic [31:0] data;
    apb_access(sgmii_apb_pkg::op_read, addr, 32'h0, data);
    cmp_addr = addr;
    cmp_got  = data;
    cmp_exp  = ref_read(addr);
    -> read_done;
  endtask

  task automatic end_test(input string name);
    @(posedge pclk);
    $display("Test %s finished with %0d errors", name, errors - test_errors_base);
    test_errors_base = errors;
  endtask

  // Read data compare
  always @(read_done)
  begin : compare_read
    checks++;
    assert (cmp_got === cmp_exp)
    else
    begin
      $display("Mismatch at %0t ns: prdata for address %h, expected %h, got %h",
               $time, cmp_addr, cmp_exp, cmp_got);
      errors++;
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial
  begin
    logic [15:0] byte_index;
    pclk             = 1'b0;
    rst_n            = 1'b0;
    apb_req          = '0;
    link_up          = 1'b0;
    an_complete      = 1'b0;
    lfsr_state       = 20'd73376;
    errors           = 0;
    checks           = 0;
    test_errors_base = 0;
    for (int i = 0; i < 16; i++)
      ref_core[i] = '0;
    for (int i = 0; i < 64; i++)
      ref_hsst[i] = '0;
    repeat (5) @(posedge pclk);
    rst_n <= 1'b1;

    // Advert and scratch words
    for (int i = 4; i < 16; i++)
      write_word(core_addr(5'(i)), rand_bits(32));
    for (int i = 4; i < 16; i++)
      read_check(core_addr(5'(i)));
    end_test("core readback");

    write_word(core_addr(5'd4), rand_bits(32));
    read_check(core_addr(5'd4));
    write_word(hsst_addr(16'd9), rand_bits(32));
    read_check(hsst_addr(16'd9));
    end_test("access timing");

    for (int i = 0; i < 16; i++)
    begin
      byte_index = 16'(rand_bits(6));
      write_word(hsst_addr(byte_index), rand_bits(32));
      read_check(hsst_addr(byte_index));
      read_check(hsst_addr(byte_index + 16'd64));
    end
    end_test("serdes bytes");

    for (int i = 0; i < 4; i++)
    begin
      link_up     <= i[0];
      an_complete <= i[1];
      read_check(core_addr(5'd1));
    end
    for (int i = 1; i < 4; i++)
    begin
      write_word(core_addr(5'(i)), rand_bits(32));
      read_check(core_addr(5'(i)));
    end
    for (int i = 16; i < 32; i++)
      read_check(core_addr(5'(i)));
    end_test("read only map");

    // Same paddr[6:2] on both sides, each side written after the other
    write_word(core_addr(5'd5), rand_bits(32));
    write_word(hsst_addr(16'd5), rand_bits(32));
    read_check(core_addr(5'd5));
    write_word(core_addr(5'd5), rand_bits(32));
    read_check(hsst_addr(16'd5));
    read_check(core_addr(5'd5));
    end_test("target isolation");

    write_word(core_addr(5'd0), rand_bits(32) & 32'h0000_7fff);
    read_check(core_addr(5'd0));
    write_word(core_addr(5'd0), rand_bits(32) | 32'h0000_8000);
    for (int i = 0; i < 16; i++)
      if (i == 0 || i >= 4)
        read_check(core_addr(5'(i)));
    read_check(hsst_addr(16'd0));
    read_check(hsst_addr(16'd5));
    read_check(hsst_addr(16'd9));
    read_check(hsst_addr(16'd63));
    end_test("soft reset");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: verilog.f
verilog/sgmii_apb_pkg.sv
verilog/sgmii_reg_pkg.sv
verilog/sgmii_apb_union.sv
verilog/sgmii_core_regs.sv
verilog/hsst_apb_bank.sv
verilog/sgmii_mgmt_top.sv
sim/tb_sgmii_mgmt.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SGMII management testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim_run.log

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_sgmii_mgmt -o tb_sgmii_mgmt --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_sgmii_mgmt > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$log"; then
  exit 1
fi
exit 0
